//--- source/picPkg.sv
package picPkg;

  typedef logic [7:0] irqVec;    // One bit per interrupt level
  typedef logic [2:0] irqLevel;  // Level number 0 to 7
  typedef logic [2:0] wbAddr;    // Register address
  typedef logic [7:0] wbData;    // Bus data word

  // Register map
  localparam wbAddr addrVectorBase = 3'd0;  // Upper five vector bits
  localparam wbAddr addrMode       = 3'd1;  // Bit 0 level mode, bit 1 auto EOI
  localparam wbAddr addrMask       = 3'd2;  // OCW1
  localparam wbAddr addrCommand    = 3'd3;  // OCW2, write only
  localparam wbAddr addrIrr        = 3'd4;  // Read only
  localparam wbAddr addrIsr        = 3'd5;  // Read only
  localparam wbAddr addrAck        = 3'd6;  // Acknowledge read

  // OCW2 command field, data bits 7 to 5
  localparam logic [2:0] cmdNonSpecificEoi       = 3'b001;
  localparam logic [2:0] cmdSpecificEoi          = 3'b011;
  localparam logic [2:0] cmdRotateNonSpecificEoi = 3'b101;
  localparam logic [2:0] cmdSetPriority          = 3'b110;

  // Bus acknowledge state
  typedef enum logic {
    busIdle,  // Waiting for cyc and stb
    busAck    // Ack cycle
  } busState;

endpackage

//--- source/requestLatch.sv
`timescale 1ns/1ps

module requestLatch (
  input  logic            clk,
  input  logic            rstN,
  input  picPkg::irqVec   ir,         // Raw request lines
  input  logic            levelMode,  // 1 = level triggered
  input  logic            ackPulse,   // Acknowledge of winLevel
  input  picPkg::irqLevel winLevel,
  output picPkg::irqVec   irr
);

  picPkg::irqVec irPrev;  // Previous ir sample
  picPkg::irqVec rise;    // Rising edges this cycle
  picPkg::irqVec clrVec;  // Bit cleared by acknowledge

  assign rise   = ir & ~irPrev;
  assign clrVec = ackPulse ? (picPkg::irqVec'(1) << winLevel) : '0;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      irPrev <= '0;
      irr    <= '0;
    end else begin
      irPrev <= ir;
      if (levelMode) begin
        irr <= ir;                     // Held line keeps requesting
      end else begin
        irr <= (irr & ~clrVec) | rise; // New edge wins over a clear
      end
    end
  end

  // In edge mode a request only goes away through its own acknowledge
  aEdgeClearOnlyByAck: assert property (
    @(posedge clk) disable iff (!rstN)
    ($past(!levelMode) && |($past(irr) & ~irr)) |->
      ($past(ackPulse) && (($past(irr) & ~irr) == (picPkg::irqVec'(1) << $past(winLevel))))
  );

endmodule

//--- source/priorityResolver.sv
`timescale 1ns/1ps

module priorityResolver (
  input  picPkg::irqVec   irr,
  input  picPkg::irqVec   mask,
  input  picPkg::irqVec   isr,
  input  picPkg::irqLevel lowestLevel,  // Rotation pointer
  output logic            intr,
  output picPkg::irqLevel winLevel,     // Highest unmasked request
  output picPkg::irqLevel isrTop,       // Highest in-service level
  output logic            isrAny
);

  picPkg::irqVec   pending;  // Unmasked requests
  logic            reqFound;
  picPkg::irqLevel reqRank;  // Position in circular order, 0 is highest
  picPkg::irqLevel isrRank;

  assign pending = irr & ~mask;

  // Circular search from lowestLevel + 1
  // Pointer at 7 gives fixed priority with level 0 on top
  always_comb begin : search
    picPkg::irqLevel lvl;
    lvl      = '0;
    reqFound = 1'b0;
    reqRank  = '0;
    winLevel = lowestLevel;  // Default when nothing pends
    isrAny   = 1'b0;
    isrRank  = '0;
    isrTop   = lowestLevel;
    for (int i = 0; i < 8; i++) begin
      lvl = lowestLevel + picPkg::irqLevel'(i + 1);
      if (!reqFound && pending[lvl]) begin
        reqFound = 1'b1;
        reqRank  = picPkg::irqLevel'(i);
        winLevel = lvl;
      end
      if (!isrAny && isr[lvl]) begin
        isrAny  = 1'b1;       // First hit is the top level
        isrRank = picPkg::irqLevel'(i);
        isrTop  = lvl;
      end
    end
  end

  // Request must outrank every level in service
  // Same level as the service one stays blocked
  assign intr = reqFound && (!isrAny || (reqRank < isrRank));

endmodule

//--- source/inServiceRegister.sv
`timescale 1ns/1ps

module inServiceRegister (
  input  logic            clk,
  input  logic            rstN,
  input  logic            ackPulse,
  input  picPkg::irqLevel winLevel,
  input  logic            autoEoi,
  input  logic            eoiPulse,
  input  logic [2:0]      eoiCmd,      // OCW2 bits 7 to 5
  input  picPkg::irqLevel eoiLevel,    // OCW2 bits 2 to 0
  input  picPkg::irqLevel isrTop,
  input  logic            isrAny,
  output picPkg::irqVec   isr,
  output picPkg::irqLevel lowestLevel  // Lowest priority level
);

  logic          rotateMode;  // Rotation requested last
  picPkg::irqVec setVec;
  picPkg::irqVec clrVec;

  // Auto EOI never marks a level in service
  assign setVec = (ackPulse && !autoEoi) ? (picPkg::irqVec'(1) << winLevel) : '0;

  always_comb begin
    clrVec = '0;
    if (eoiPulse) begin
      case (eoiCmd)
        picPkg::cmdNonSpecificEoi,
        picPkg::cmdRotateNonSpecificEoi: begin
          if (isrAny) clrVec = picPkg::irqVec'(1) << isrTop;  // Top in-service level
        end
        picPkg::cmdSpecificEoi: clrVec = picPkg::irqVec'(1) << eoiLevel;
        default: clrVec = '0;  // Set priority and unused codes
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      isr         <= '0;
      lowestLevel <= 3'd7;  // Fixed priority after reset
      rotateMode  <= 1'b0;
    end else begin
      isr <= (isr & ~clrVec) | setVec;
      if (ackPulse && autoEoi && rotateMode) begin
        lowestLevel <= winLevel;  // Auto rotate
      end
      if (eoiPulse) begin
        case (eoiCmd)
          picPkg::cmdNonSpecificEoi: rotateMode <= 1'b0;
          picPkg::cmdSpecificEoi:    rotateMode <= 1'b0;
          picPkg::cmdRotateNonSpecificEoi: begin
            rotateMode <= 1'b1;
            if (isrAny) lowestLevel <= isrTop;  // Serviced level drops to bottom
          end
          picPkg::cmdSetPriority: lowestLevel <= eoiLevel;
          default: rotateMode <= rotateMode;
        endcase
      end
    end
  end

  // Resolver only lets through a level above all in-service ones
  aNoDoubleSet: assert property (
    @(posedge clk) disable iff (!rstN)
    (ackPulse && !autoEoi) |-> !isr[winLevel]
  );

endmodule

//--- source/busControl.sv
`timescale 1ns/1ps

module busControl (
  input  logic            clk,
  input  logic            rstN,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  picPkg::wbAddr   adr,
  input  picPkg::wbData   datW,
  output picPkg::wbData   datR,
  output logic            ack,
  input  picPkg::irqVec   irr,
  input  picPkg::irqVec   isr,
  input  picPkg::irqLevel winLevel,
  input  logic            intr,
  output logic            levelMode,
  output logic            autoEoi,
  output picPkg::irqVec   mask,
  output logic            ackPulse,   // Completed acknowledge read
  output logic            eoiPulse,   // Completed command write
  output logic [2:0]      eoiCmd,
  output picPkg::irqLevel eoiLevel
);

  picPkg::busState state;
  logic [4:0]      vectorBase;  // ICW2 upper bits
  logic            wrDone;
  logic            rdDone;
  picPkg::wbData   vector;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= picPkg::busIdle;
    end else begin
      case (state)
        picPkg::busIdle: if (cyc && stb) state <= picPkg::busAck;
        picPkg::busAck:  state <= picPkg::busIdle;  // One idle cycle between accesses
        default:         state <= picPkg::busIdle;
      endcase
    end
  end

  assign ack    = (state == picPkg::busAck);
  assign wrDone = ack && we;
  assign rdDone = ack && !we;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      vectorBase <= '0;
      levelMode  <= 1'b0;
      autoEoi    <= 1'b0;
      mask       <= '0;
    end else if (wrDone) begin
      case (adr)
        picPkg::addrVectorBase: vectorBase <= datW[7:3];
        picPkg::addrMode:       {autoEoi, levelMode} <= datW[1:0];
        picPkg::addrMask:       mask <= datW;
        default:                mask <= mask;  // Command and read-only addresses
      endcase
    end
  end

  // Spurious acknowledge sets nothing and returns level 7
  assign ackPulse = rdDone && (adr == picPkg::addrAck) && intr;
  assign eoiPulse = wrDone && (adr == picPkg::addrCommand);
  assign eoiCmd   = datW[7:5];
  assign eoiLevel = datW[2:0];
  assign vector   = {vectorBase, intr ? winLevel : 3'd7};

  always_comb begin
    case (adr)
      picPkg::addrVectorBase: datR = {vectorBase, 3'b000};
      picPkg::addrMode:       datR = {6'b0, autoEoi, levelMode};
      picPkg::addrMask:       datR = mask;
      picPkg::addrIrr:        datR = irr;
      picPkg::addrIsr:        datR = isr;
      picPkg::addrAck:        datR = vector;  // Same cycle as the ISR set
      default:                datR = '0;
    endcase
  end

  // Master holds the strobe until it sees ack
  aAckInCycle: assert property (
    @(posedge clk) disable iff (!rstN)
    ack |-> (cyc && stb)
  );

endmodule

//--- source/interruptController.sv
`timescale 1ns/1ps

module interruptController (
  input  logic          clk,
  input  logic          rstN,
  input  logic          cyc,
  input  logic          stb,
  input  logic          we,
  input  picPkg::wbAddr adr,
  input  picPkg::wbData datW,
  output picPkg::wbData datR,
  output logic          ack,
  input  picPkg::irqVec ir,
  output logic          intr
);

  logic            levelMode;
  logic            autoEoi;
  picPkg::irqVec   mask;
  logic            ackPulse;
  logic            eoiPulse;
  logic [2:0]      eoiCmd;
  picPkg::irqLevel eoiLevel;
  picPkg::irqVec   irr;
  picPkg::irqVec   isr;
  picPkg::irqLevel winLevel;
  picPkg::irqLevel isrTop;
  logic            isrAny;
  picPkg::irqLevel lowestLevel;

  requestLatch uLatch (
    .clk, .rstN, .ir, .levelMode, .ackPulse, .winLevel, .irr
  );

  priorityResolver uResolver (
    .irr, .mask, .isr, .lowestLevel, .intr, .winLevel, .isrTop, .isrAny
  );

  inServiceRegister uIsr (
    .clk, .rstN, .ackPulse, .winLevel, .autoEoi, .eoiPulse, .eoiCmd,
    .eoiLevel, .isrTop, .isrAny, .isr, .lowestLevel
  );

  busControl uBus (
    .clk, .rstN, .cyc, .stb, .we, .adr, .datW, .datR, .ack, .irr, .isr,
    .winLevel, .intr, .levelMode, .autoEoi, .mask, .ackPulse, .eoiPulse,
    .eoiCmd, .eoiLevel
  );

endmodule

//--- dv/picChecker.sv
`timescale 1ns/1ps

module picChecker (
  input  logic          clk,
  input  logic          rstN,
  input  logic          ack,
  input  logic          we,
  input  picPkg::wbAddr adr,
  input  picPkg::wbData datR,
  input  logic          intr,
  input  logic          expAck,   // Model outputs
  input  logic          expIntr,
  input  picPkg::wbData expVec,
  input  picPkg::irqVec expIsr,
  input  picPkg::irqVec expIrr,
  input  picPkg::irqVec expMask,
  input  logic [4:0]    expBase,
  input  logic [1:0]    expMode,  // {auto EOI, level mode}
  output int            checks,
  output int            errors
);

  int nChecks = 0;
  int nErrors = 0;

  assign checks = nChecks;
  assign errors = nErrors;

  task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
    nChecks++;
    if (got !== exp) begin
      nErrors++;
      $display("Error: %s expected %h, got %h at %0t", name, exp, got, $time);
    end
  endtask

  // Sample on the falling edge halfway between input changes and DUT updates
  always @(negedge clk) begin
    if (rstN) begin
      compare("ack", {7'b0, expAck}, {7'b0, ack});
      compare("intr", {7'b0, expIntr}, {7'b0, intr});
      if (ack && !we) begin
        case (adr)
          picPkg::addrVectorBase: compare("datR (base)", {expBase, 3'b000}, datR);
          picPkg::addrMode:       compare("datR (mode)", {6'b0, expMode}, datR);
          picPkg::addrAck:  compare("datR (vector)", expVec, datR);
          picPkg::addrIsr:  compare("datR (isr)", expIsr, datR);
          picPkg::addrIrr:  compare("datR (irr)", expIrr, datR);
          picPkg::addrMask: compare("datR (mask)", expMask, datR);
          default: ;  // Command address is write only
        endcase
      end
    end
  end

endmodule

//--- dv/tbInterruptController.sv
`timescale 1ns/1ps

module tbInterruptController;

  localparam int numRandom = 20;  // Random request rounds
  localparam int numTests  = 6 + numRandom;

  logic          clk;
  logic          rstN;
  logic          cyc;
  logic          stb;
  logic          we;
  picPkg::wbAddr adr;
  picPkg::wbData datW;
  picPkg::wbData datR;
  logic          ack;
  picPkg::irqVec ir;
  logic          intr;

  // Reference model state
  logic            mAck;
  picPkg::irqVec   mIrr;
  picPkg::irqVec   mIrPrev;
  picPkg::irqVec   mMask;
  picPkg::irqVec   mIsr;
  picPkg::irqLevel mLowest;
  logic [4:0]      mBase;
  logic            mLevel;
  logic            mAuto;
  logic            mRotate;
  logic            expIntr;
  picPkg::wbData   expVec;

  picPkg::wbData rdData;
  int            seed = 3988;
  logic [31:0]   rnd;
  int            tbErrors = 0;
  int            tbChecks = 0;
  int            chkChecks;
  int            chkErrors;

  interruptController dut (
    .clk, .rstN, .cyc, .stb, .we, .adr, .datW, .datR, .ack, .ir, .intr
  );

  picChecker chk (
    .clk, .rstN, .ack, .we, .adr, .datR, .intr, .expAck(mAck), .expIntr,
    .expVec, .expIsr(mIsr), .expIrr(mIrr), .expMask(mMask), .expBase(mBase),
    .expMode({mAuto, mLevel}), .checks(chkChecks), .errors(chkErrors)
  );

  always #5 clk = ~clk;

  // Circular distance below the lowest-priority level with 0 on top
  function automatic int rankOf(input picPkg::irqLevel level, input picPkg::irqLevel lowest);
    return (int'(level) + 7 - int'(lowest)) % 8;
  endfunction

  // {found, level} of the best-ranked set bit
  function automatic logic [3:0] bestLevel(input picPkg::irqVec bits,
                                           input picPkg::irqLevel lowest);
    int         best;
    logic [3:0] pick;
    best = 8;
    pick = 4'b0;
    for (int l = 0; l < 8; l++) begin
      if (bits[l] && rankOf(l[2:0], lowest) < best) begin
        best = rankOf(l[2:0], lowest);
        pick = {1'b1, l[2:0]};
      end
    end
    return pick;
  endfunction

  function automatic logic modelIntr(input picPkg::irqVec irr, input picPkg::irqVec mask,
                                     input picPkg::irqVec isr, input picPkg::irqLevel lowest);
    logic [3:0] req;
    logic [3:0] top;
    req = bestLevel(irr & ~mask, lowest);
    top = bestLevel(isr, lowest);
    return req[3] && (!top[3] || rankOf(req[2:0], lowest) < rankOf(top[2:0], lowest));
  endfunction

  // Level 7 vector when nothing may be granted
  function automatic picPkg::wbData expectedVector(input picPkg::irqVec irr,
      input picPkg::irqVec mask, input picPkg::irqVec isr, input picPkg::irqLevel lowest,
      input logic [4:0] base);
    logic [3:0] req;
    req = bestLevel(irr & ~mask, lowest);
    return {base, modelIntr(irr, mask, isr, lowest) ? req[2:0] : 3'd7};
  endfunction

  assign expIntr = modelIntr(mIrr, mMask, mIsr, mLowest);
  assign expVec  = expectedVector(mIrr, mMask, mIsr, mLowest, mBase);

  always @(posedge clk or negedge rstN) begin : model
    logic [3:0]    req;
    logic [3:0]    top;
    logic          grant;
    picPkg::irqVec irrClr;
    picPkg::irqVec isrNext;
    if (!rstN) begin
      mAck    <= 1'b0;
      mIrr    <= '0;
      mIrPrev <= '0;
      mMask   <= '0;
      mIsr    <= '0;
      mLowest <= 3'd7;
      mBase   <= '0;
      mLevel  <= 1'b0;
      mAuto   <= 1'b0;
      mRotate <= 1'b0;
    end else begin
      req     = bestLevel(mIrr & ~mMask, mLowest);
      top     = bestLevel(mIsr, mLowest);
      grant   = mAck && !we && (adr == picPkg::addrAck) && expIntr;
      irrClr  = grant ? (picPkg::irqVec'(1) << req[2:0]) : '0;
      isrNext = mIsr;
      mAck    <= !mAck && cyc && stb;  // One ack cycle then back to idle
      mIrPrev <= ir;
      mIrr    <= mLevel ? ir : ((mIrr & ~irrClr) | (ir & ~mIrPrev));
      if (grant) begin
        if (!mAuto) isrNext[req[2:0]] = 1'b1;
        else if (mRotate) mLowest <= req[2:0];
      end
      if (mAck && we) begin
        case (adr)
          picPkg::addrVectorBase: mBase <= datW[7:3];
          picPkg::addrMode: begin
            mLevel <= datW[0];
            mAuto  <= datW[1];
          end
          picPkg::addrMask: mMask <= datW;
          picPkg::addrCommand: begin
            case (datW[7:5])
              picPkg::cmdNonSpecificEoi: begin
                if (top[3]) isrNext[top[2:0]] = 1'b0;
                mRotate <= 1'b0;
              end
              picPkg::cmdSpecificEoi: begin
                isrNext[datW[2:0]] = 1'b0;
                mRotate <= 1'b0;
              end
              picPkg::cmdRotateNonSpecificEoi: begin
                if (top[3]) begin
                  isrNext[top[2:0]] = 1'b0;
                  mLowest <= top[2:0];  // Serviced level goes last
                end
                mRotate <= 1'b1;
              end
              picPkg::cmdSetPriority: mLowest <= datW[2:0];
              default: ;
            endcase
          end
          default: ;
        endcase
      end
      mIsr <= isrNext;
    end
  end

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Holds the strobe until ack and leaves one idle cycle after it
  task automatic busCycle(input logic write, input picPkg::wbAddr addr,
                          input picPkg::wbData data, output picPkg::wbData rdata);
    int waited;
    waited = 0;
    cyc  = 1'b1;
    stb  = 1'b1;
    we   = write;
    adr  = addr;
    datW = data;
    @(negedge clk);
    while (!ack && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (!ack) begin
      $display("Bus access to address %0d was never acknowledged", addr);
      tbErrors++;
    end
    rdata = datR;
    idle(1);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    idle(1);
  endtask

  task automatic wbWrite(input picPkg::wbAddr addr, input picPkg::wbData data);
    picPkg::wbData unused;
    busCycle(1'b1, addr, data, unused);
  endtask

  task automatic wbRead(input picPkg::wbAddr addr, output picPkg::wbData data);
    busCycle(1'b0, addr, 8'h00, data);
  endtask

  task automatic acknowledge();
    wbRead(picPkg::addrAck, rdData);
  endtask

  task automatic sendCommand(input logic [2:0] cmd, input picPkg::irqLevel level);
    wbWrite(picPkg::addrCommand, {cmd, 2'b00, level});
  endtask

  task automatic pulseIr(input picPkg::irqVec lines);
    ir = lines;
    idle(1);
    ir = '0;
    idle(1);
  endtask

  // Direct check against a fixed value
  task automatic expectRead(input picPkg::wbAddr addr, input picPkg::wbData exp,
                            input string name);
    wbRead(addr, rdData);
    tbChecks++;
    if (rdData !== exp) begin
      $display("Error: datR (%s) expected %h, got %h", name, exp, rdData);
      tbErrors++;
    end
  endtask

  initial begin
    repeat (numTests * 100) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", numTests * 100);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    clk  = 1'b0;
    rstN = 1'b0;
    cyc  = 1'b0;
    stb  = 1'b0;
    we   = 1'b0;
    adr  = '0;
    datW = '0;
    ir   = '0;
    repeat (16) @(posedge clk);
    #1 rstN = 1'b1;

    expectRead(picPkg::addrIrr, 8'h00, "irr after reset");
    expectRead(picPkg::addrIsr, 8'h00, "isr after reset");
    expectRead(picPkg::addrMask, 8'h00, "mask after reset");

    // Fixed priority edge requests with nesting
    wbWrite(picPkg::addrVectorBase, 8'h40);
    wbRead(picPkg::addrVectorBase, rdData);
    wbWrite(picPkg::addrMode, 8'h00);
    pulseIr(8'h28);
    acknowledge();          // Level 3
    pulseIr(8'h02);
    acknowledge();          // Level 1 nests
    pulseIr(8'h40);         // Level 6 waits
    expectRead(picPkg::addrIsr, 8'h0a, "isr nested");

    // EOI forms
    sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);
    expectRead(picPkg::addrIsr, 8'h08, "isr after non-specific EOI");
    acknowledge();          // Spurious while level 3 blocks
    sendCommand(picPkg::cmdSpecificEoi, 3'd3);
    acknowledge();          // Level 5
    acknowledge();          // Level 6 blocked
    sendCommand(picPkg::cmdSpecificEoi, 3'd5);
    acknowledge();          // Level 6
    sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);
    pulseIr(8'h04);
    acknowledge();
    pulseIr(8'h01);
    acknowledge();
    sendCommand(picPkg::cmdSpecificEoi, 3'd2);
    expectRead(picPkg::addrIsr, 8'h01, "isr after specific EOI");
    sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);

    // Masking
    wbWrite(picPkg::addrMask, 8'h10);
    pulseIr(8'h10);
    acknowledge();          // Masked so the level 7 vector comes back
    expectRead(picPkg::addrIrr, 8'h10, "irr masked");
    wbWrite(picPkg::addrMask, 8'h00);
    acknowledge();          // Level 4 after unmask
    sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);

    // Rotation
    pulseIr(8'h24);
    acknowledge();
    sendCommand(picPkg::cmdRotateNonSpecificEoi, 3'd0);
    acknowledge();          // Level 5 under rotated order
    sendCommand(picPkg::cmdRotateNonSpecificEoi, 3'd0);
    sendCommand(picPkg::cmdSetPriority, 3'd4);
    pulseIr(8'h21);
    acknowledge();          // Level 5 beats 0
    sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);
    acknowledge();
    sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);
    for (int n = 0; n < numRandom; n++) begin
      rnd = $random(seed);
      wbWrite(picPkg::addrMask, rnd[15:8] & rnd[23:16]);  // Sparse mask
      sendCommand(picPkg::cmdSetPriority, rnd[26:24]);
      pulseIr(rnd[7:0]);
      wbRead(picPkg::addrIrr, rdData);
      for (int k = 0; k < 4; k++) begin
        acknowledge();
        sendCommand(rnd[27 + k] ? picPkg::cmdRotateNonSpecificEoi
                                : picPkg::cmdNonSpecificEoi, 3'd0);
      end
      wbRead(picPkg::addrIsr, rdData);
    end
    wbWrite(picPkg::addrMask, 8'h00);
    repeat (8) begin
      acknowledge();        // Drain leftovers
      sendCommand(picPkg::cmdNonSpecificEoi, 3'd0);
    end
    sendCommand(picPkg::cmdSetPriority, 3'd7);
    sendCommand(picPkg::cmdRotateNonSpecificEoi, 3'd0);  // Rotation on with nothing in service

    // Auto EOI and then level mode
    wbWrite(picPkg::addrMode, 8'h02);
    pulseIr(8'h90);
    acknowledge();          // Level 4 becomes the lowest level
    expectRead(picPkg::addrIsr, 8'h00, "isr with auto EOI");
    pulseIr(8'h01);
    acknowledge();          // Level 7 beats 0 after auto rotation
    acknowledge();
    wbWrite(picPkg::addrMode, 8'h03);
    wbRead(picPkg::addrMode, rdData);
    ir = 8'h40;
    idle(2);
    acknowledge();
    acknowledge();          // Held line requests again
    expectRead(picPkg::addrIrr, 8'h40, "irr held level");
    ir = 8'h00;
    idle(2);
    expectRead(picPkg::addrIrr, 8'h00, "irr released level");
    idle(4);

    $display("Checks: %0d, errors: %0d", chkChecks + tbChecks, chkErrors + tbErrors);
    if (chkErrors + tbErrors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
source/picPkg.sv
source/requestLatch.sv
source/priorityResolver.sv
source/inServiceRegister.sv
source/busControl.sv
source/interruptController.sv
dv/picChecker.sv
dv/tbInterruptController.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f \
  --top-module tbInterruptController -o simInterruptController
./obj_dir/simInterruptController | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
